// File: hdl/primDispatch_params.svh
// Widths, sizes and constants of the primitive dispatch stage
// Word addresses of the leaf register port
// Global primitive group queued on ray restart

`ifndef PRIM_DISPATCH_PARAMS_SVH
`define PRIM_DISPATCH_PARAMS_SVH

// Primitive index and count widths
`define BVH_PRIMITIVE_INDEX_WIDTH 16
`define BVH_PRIMITIVE_AMOUNT_WIDTH 8

// Lanes per AABB test unit, and log2 of it
`define AABB_TEST_UNIT_SIZE_WIDTH 2
`define AABB_TEST_UNIT_SIZE 4

// Queue pointer width, one slot kept free
`define PRIM_GROUP_FIFO_PTR_WIDTH 3

// Group queued on restart, always of type AABB
`define BVH_GLOBAL_PRIMITIVE_START_IDX 16'h0100
`define BVH_GLOBAL_PRIMITIVE_COUNT 3

// Wishbone word addresses
`define LEAF_ADDR_GROUP0 2'd0
`define LEAF_ADDR_GROUP1 2'd1
`define LEAF_ADDR_CTRL 2'd2
`define LEAF_ADDR_STATUS 2'd3

`endif

// File: hdl/primDispatchPkg.sv
// Shared types of the primitive dispatch stage
// Enums for primitive type and leaf command
// Packed structs for groups, queries, batches and the Wishbone port

`include "primDispatch_params.svh"

package primDispatchPkg;

    //----------------------------------------------------------------------
    // Enums
    //----------------------------------------------------------------------
    typedef enum logic [1:0] {
        PT_Sphere,
        PT_AABB,
        PT_Triangle
    } PrimitiveType;

    // CTRL register opcode
    typedef enum logic [1:0] {
        LC_None,
        LC_Push,
        LC_Restart
    } LeafCommand;

    //----------------------------------------------------------------------
    // Primitive ranges
    //----------------------------------------------------------------------
    // One queued range of primitives
    typedef struct packed {
        PrimitiveType PrimType;
        logic [`BVH_PRIMITIVE_INDEX_WIDTH-1:0] StartPrimitive;
        logic [`BVH_PRIMITIVE_AMOUNT_WIDTH-1:0] NumPrimitives;
    } PrimitiveGroup;

    // Leaf result, two ranges sharing one type
    typedef struct packed {
        PrimitiveType PrimType;
        logic [`BVH_PRIMITIVE_INDEX_WIDTH-1:0] Group0Start;
        logic [`BVH_PRIMITIVE_AMOUNT_WIDTH-1:0] Group0Count;
        logic [`BVH_PRIMITIVE_INDEX_WIDTH-1:0] Group1Start;
        logic [`BVH_PRIMITIVE_AMOUNT_WIDTH-1:0] Group1Count;
    } LeafPushData;

    // Range cursor, EndIndex rounded up to the unit size
    typedef struct packed {
        PrimitiveType PrimType;
        logic [`BVH_PRIMITIVE_INDEX_WIDTH-1:0] StartIndex;
        logic [`BVH_PRIMITIVE_INDEX_WIDTH-1:0] EndIndex;
        logic [`BVH_PRIMITIVE_INDEX_WIDTH-1:0] RealEndIndex;
    } PrimitiveQueryData;

    // One lane batch for the hit-test units
    typedef struct packed {
        PrimitiveType PrimType;
        logic [`BVH_PRIMITIVE_INDEX_WIDTH-1:0] BaseIndex;
        logic [`AABB_TEST_UNIT_SIZE-1:0] LaneMask;
    } PrimitiveBatch;

    //----------------------------------------------------------------------
    // Wishbone classic
    //----------------------------------------------------------------------
    typedef struct packed {
        logic Cyc;
        logic Stb;
        logic We;
        logic [1:0] Adr;
        logic [31:0] Dat;
    } WbRequest;

    typedef struct packed {
        logic Ack;
        logic [31:0] Dat;
    } WbResponse;

endpackage

// File: hdl/leafRegs.sv
// Wishbone classic slave for leaf results
// GROUP0 and GROUP1 range registers, CTRL decode and STATUS readback
// Push and restart pulse for the single Ack cycle of a CTRL write

`timescale 1ns/10ps
`include "primDispatch_params.svh"

module leafRegs (
    input  logic clk,
    input  logic resetn,
    input  primDispatchPkg::WbRequest wbReq,
    output primDispatchPkg::WbResponse wbRsp,
    input  logic idle,
    input  logic overflow,
    input  logic [`PRIM_GROUP_FIFO_PTR_WIDTH-1:0] groupCount,
    output logic push,
    output logic restart,
    output primDispatchPkg::LeafPushData pushData
);

    localparam int indexWidth = `BVH_PRIMITIVE_INDEX_WIDTH;
    localparam int groupBits = `BVH_PRIMITIVE_INDEX_WIDTH + `BVH_PRIMITIVE_AMOUNT_WIDTH;

    logic ack;
    logic wrStrobe;
    logic ctrlWrite;
    logic [groupBits-1:0] group0Reg;
    logic [groupBits-1:0] group1Reg;
    logic [31:0] statusWord;
    logic [31:0] readData;
    primDispatchPkg::LeafCommand ctrlCmd;
    primDispatchPkg::PrimitiveType ctrlType;

    // Ack one cycle after request, dropped for one cycle after
    always_ff @(posedge clk, negedge resetn) begin
        if (!resetn) begin
            ack <= 1'b0;
        end else begin
            ack <= wbReq.Cyc && wbReq.Stb && !ack;
        end
    end

    // Writes take effect in the Ack cycle
    assign wrStrobe = ack && wbReq.Cyc && wbReq.Stb && wbReq.We;
    assign ctrlWrite = wrStrobe && (wbReq.Adr == `LEAF_ADDR_CTRL);

    // Range registers, start in low bits, count above
    always_ff @(posedge clk) begin
        if (wrStrobe && (wbReq.Adr == `LEAF_ADDR_GROUP0)) begin
            group0Reg <= wbReq.Dat[groupBits-1:0];
        end
        if (wrStrobe && (wbReq.Adr == `LEAF_ADDR_GROUP1)) begin
            group1Reg <= wbReq.Dat[groupBits-1:0];
        end
    end

    //----------------------------------------------------------------------
    // CTRL decode
    //----------------------------------------------------------------------
    assign ctrlCmd = primDispatchPkg::LeafCommand'(wbReq.Dat[1:0]);
    assign ctrlType = primDispatchPkg::PrimitiveType'(wbReq.Dat[3:2]);

    assign push = ctrlWrite && (ctrlCmd == primDispatchPkg::LC_Push);
    assign restart = ctrlWrite && (ctrlCmd == primDispatchPkg::LC_Restart);

    // Type comes with the CTRL write itself
    assign pushData.PrimType = ctrlType;
    assign pushData.Group0Start = group0Reg[indexWidth-1:0];
    assign pushData.Group0Count = group0Reg[groupBits-1:indexWidth];
    assign pushData.Group1Start = group1Reg[indexWidth-1:0];
    assign pushData.Group1Count = group1Reg[groupBits-1:indexWidth];

    //----------------------------------------------------------------------
    // Readback
    //----------------------------------------------------------------------
    always_comb begin
        statusWord = '0;
        statusWord[0] = idle;
        statusWord[1] = overflow;
        statusWord[4 +: `PRIM_GROUP_FIFO_PTR_WIDTH] = groupCount;
    end

    // CTRL reads back as zero
    always_comb begin
        case (wbReq.Adr)
            `LEAF_ADDR_GROUP0: readData = 32'(group0Reg);
            `LEAF_ADDR_GROUP1: readData = 32'(group1Reg);
            `LEAF_ADDR_STATUS: readData = statusWord;
            default: readData = '0;
        endcase
    end

    assign wbRsp.Ack = ack;
    assign wbRsp.Dat = readData;

endmodule

// File: hdl/primitiveQueue.sv
// Circular FIFO of primitive groups, two groups per push
// Range cursor over the dequeued group in aligned unit steps
// Sticky overflow flag and restart with the global group

`timescale 1ns/10ps
`include "primDispatch_params.svh"

module primitiveQueue (
    input  logic clk,
    input  logic resetn,
    input  logic push,
    input  logic restart,
    input  primDispatchPkg::LeafPushData pushData,
    input  logic advance,
    input  logic load,
    output primDispatchPkg::PrimitiveQueryData query,
    output logic queryValid,
    output logic groupAvailable,
    output logic [`PRIM_GROUP_FIFO_PTR_WIDTH-1:0] groupCount,
    output logic overflow
);

    localparam int ptrWidth = `PRIM_GROUP_FIFO_PTR_WIDTH;
    localparam int indexWidth = `BVH_PRIMITIVE_INDEX_WIDTH;
    localparam int amountWidth = `BVH_PRIMITIVE_AMOUNT_WIDTH;
    localparam int depth = 1 << ptrWidth;
    localparam logic [indexWidth-1:0] unitSize = indexWidth'(`AABB_TEST_UNIT_SIZE);

    primDispatchPkg::PrimitiveGroup groups [depth];
    primDispatchPkg::PrimitiveGroup group0;
    primDispatchPkg::PrimitiveGroup group1;
    primDispatchPkg::PrimitiveGroup headGroup;
    primDispatchPkg::PrimitiveGroup globalGroup;
    primDispatchPkg::PrimitiveType curType;

    logic [ptrWidth-1:0] top;
    logic [ptrWidth-1:0] bottom;
    logic [ptrWidth-1:0] group1Slot;
    logic [ptrWidth-1:0] freeCount;
    logic [ptrWidth-1:0] needed;
    logic hasGroup0;
    logic hasGroup1;
    logic accept;
    logic overflowFlag;

    logic [indexWidth-1:0] startIndex;
    logic [indexWidth-1:0] endIndex;
    logic [indexWidth-1:0] realEndIndex;
    logic [indexWidth-1:0] headCount;
    logic [indexWidth-1:0] headRealEnd;
    logic [indexWidth-1:0] headAlignedEnd;

    //----------------------------------------------------------------------
    // Push side
    //----------------------------------------------------------------------
    assign group0 = '{pushData.PrimType, pushData.Group0Start, pushData.Group0Count};
    assign group1 = '{pushData.PrimType, pushData.Group1Start, pushData.Group1Count};

    // Zero-count ranges are skipped
    assign hasGroup0 = (pushData.Group0Count != '0);
    assign hasGroup1 = (pushData.Group1Count != '0);

    always_comb begin
        needed = '0;
        if (hasGroup0) needed = needed + 1'b1;
        if (hasGroup1) needed = needed + 1'b1;
    end

    // One slot always stays empty to tell full from empty
    assign groupCount = bottom - top;
    assign freeCount = ptrWidth'(depth - 1) - groupCount;

    // All or nothing, a partial push is never queued
    assign accept = push && (needed <= freeCount);

    // Group1 lands right behind Group0, or in its place
    assign group1Slot = hasGroup0 ? bottom + 1'b1 : bottom;

    assign globalGroup = '{primDispatchPkg::PT_AABB, `BVH_GLOBAL_PRIMITIVE_START_IDX,
                           amountWidth'(`BVH_GLOBAL_PRIMITIVE_COUNT)};

    always_ff @(posedge clk) begin
        if (restart) begin
            groups[0] <= globalGroup;
        end else if (accept) begin
            if (hasGroup0) groups[bottom] <= group0;
            if (hasGroup1) groups[group1Slot] <= group1;
        end
    end

    //----------------------------------------------------------------------
    // Head group ends
    //----------------------------------------------------------------------
    assign headGroup = groups[top];
    assign headCount = indexWidth'(headGroup.NumPrimitives);
    assign headRealEnd = headGroup.StartPrimitive + headCount;

    // Count rounded up to whole units
    assign headAlignedEnd = headGroup.StartPrimitive +
        (((headCount + unitSize - 1'b1) >> `AABB_TEST_UNIT_SIZE_WIDTH)
         << `AABB_TEST_UNIT_SIZE_WIDTH);

    //----------------------------------------------------------------------
    // Pointers, cursor and overflow
    //----------------------------------------------------------------------
    always_ff @(posedge clk, negedge resetn) begin
        if (!resetn) begin
            top <= '0;
            bottom <= '0;
            overflowFlag <= 1'b0;
            curType <= primDispatchPkg::PT_Sphere;
            startIndex <= '0;
            endIndex <= '0;
            realEndIndex <= '0;
        end else if (restart) begin
            // Global group becomes the only entry
            top <= '0;
            bottom <= ptrWidth'(1);
            overflowFlag <= 1'b0;
            startIndex <= '0;
            endIndex <= '0;
            realEndIndex <= '0;
        end else begin
            if (accept) begin
                bottom <= bottom + needed;
            end else if (push) begin
                overflowFlag <= 1'b1;
            end

            // Issuer guarantees load and advance are exclusive
            if (load) begin
                top <= top + 1'b1;
                curType <= headGroup.PrimType;
                startIndex <= headGroup.StartPrimitive;
                endIndex <= headAlignedEnd;
                realEndIndex <= headRealEnd;
            end else if (advance) begin
                startIndex <= startIndex + unitSize;
            end
        end
    end

    assign query = '{curType, startIndex, endIndex, realEndIndex};
    assign queryValid = (startIndex < endIndex);
    assign groupAvailable = (top != bottom);
    assign overflow = overflowFlag;

endmodule

// File: hdl/batchIssue.sv
// Lane batch output register with valid/take handshake
// Lane masks against the real range end
// Drives cursor advance and group load of the queue

`timescale 1ns/10ps
`include "primDispatch_params.svh"

module batchIssue (
    input  logic clk,
    input  logic resetn,
    input  primDispatchPkg::PrimitiveQueryData query,
    input  logic queryValid,
    input  logic groupAvailable,
    output logic advance,
    output logic load,
    output primDispatchPkg::PrimitiveBatch batch,
    output logic batchValid,
    input  logic batchTake,
    output logic idle
);

    localparam int indexWidth = `BVH_PRIMITIVE_INDEX_WIDTH;
    localparam int laneCount = `AABB_TEST_UNIT_SIZE;

    logic slotFree;
    logic [laneCount-1:0] nextMask;

    // Register empty, or emptied by a take this cycle
    assign slotFree = !batchValid || batchTake;

    // Capture and step the cursor together
    assign advance = slotFree && queryValid;

    // Next group as soon as the cursor runs out, even under back-pressure
    assign load = !queryValid && groupAvailable;

    // Lanes past the real end stay off
    always_comb begin
        for (int i = 0; i < laneCount; i++) begin
            nextMask[i] = (query.StartIndex + indexWidth'(i)) < query.RealEndIndex;
        end
    end

    always_ff @(posedge clk, negedge resetn) begin
        if (!resetn) begin
            batchValid <= 1'b0;
        end else if (advance) begin
            batchValid <= 1'b1;
        end else if (batchTake) begin
            batchValid <= 1'b0;
        end
    end

    // Payload held until the next capture
    always_ff @(posedge clk) begin
        if (advance) begin
            batch <= '{query.PrimType, query.StartIndex, nextMask};
        end
    end

    assign idle = !batchValid && !queryValid && !groupAvailable;

endmodule

// File: hdl/primDispatch.sv
// Primitive dispatch stage top level
// Chain of leaf register port, primitive queue and batch issuer

`timescale 1ns/10ps
`include "primDispatch_params.svh"

module primDispatch (
    input  logic clk,
    input  logic resetn,
    input  primDispatchPkg::WbRequest wbReq,
    output primDispatchPkg::WbResponse wbRsp,
    output primDispatchPkg::PrimitiveBatch batch,
    output logic batchValid,
    input  logic batchTake
);

    // Port to queue
    logic push;
    logic restart;
    primDispatchPkg::LeafPushData pushData;

    // Status back to the port
    logic idle;
    logic overflow;
    logic [`PRIM_GROUP_FIFO_PTR_WIDTH-1:0] groupCount;

    // Queue to issuer
    primDispatchPkg::PrimitiveQueryData query;
    logic queryValid;
    logic groupAvailable;
    logic advance;
    logic load;

    leafRegs uLeafRegs (
        .clk(clk),
        .resetn(resetn),
        .wbReq(wbReq),
        .wbRsp(wbRsp),
        .idle(idle),
        .overflow(overflow),
        .groupCount(groupCount),
        .push(push),
        .restart(restart),
        .pushData(pushData)
    );

    primitiveQueue uPrimitiveQueue (
        .clk(clk),
        .resetn(resetn),
        .push(push),
        .restart(restart),
        .pushData(pushData),
        .advance(advance),
        .load(load),
        .query(query),
        .queryValid(queryValid),
        .groupAvailable(groupAvailable),
        .groupCount(groupCount),
        .overflow(overflow)
    );

    batchIssue uBatchIssue (
        .clk(clk),
        .resetn(resetn),
        .query(query),
        .queryValid(queryValid),
        .groupAvailable(groupAvailable),
        .advance(advance),
        .load(load),
        .batch(batch),
        .batchValid(batchValid),
        .batchTake(batchTake),
        .idle(idle)
    );

endmodule

// File: verif/tbClock.sv
// Testbench clock at 10 ns period
// Active low reset held for the first 16 cycles

`timescale 1ns/10ps

module tbClock (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

// File: verif/tbChecker.sv
// Expected batch model of the dispatch stage
// Watches Wishbone writes, tracks FIFO occupancy, compares taken batches
// Error count and the pending batch count for the testbench top

`timescale 1ns/10ps
`include "primDispatch_params.svh"

module tbChecker (
    input  logic clk,
    input  logic resetn,
    input  primDispatchPkg::WbRequest wbReq,
    input  primDispatchPkg::WbResponse wbRsp,
    input  primDispatchPkg::PrimitiveBatch batch,
    input  logic batchValid,
    input  logic batchTake,
    input  logic load,
    input  logic finalCheck,
    output int errorCount,
    output int pendingCount
);

    primDispatchPkg::PrimitiveBatch expected[$];
    logic [31:0] group0Shadow;
    logic [31:0] group1Shadow;
    int occupancy;
    int errors = 0;

    // Batches of one range from the start up to the rounded-up end
    task automatic appendGroup(input logic [1:0] primType, input int start, input int count);
        primDispatchPkg::PrimitiveBatch b;
        int alignedEnd;
        int realEnd;
        alignedEnd = start + ((count + 3) / 4) * 4;
        realEnd = start + count;
        for (int base = start; base < alignedEnd; base += 4) begin
            b.PrimType = primDispatchPkg::PrimitiveType'(primType);
            b.BaseIndex = base[15:0];
            for (int i = 0; i < 4; i++) begin
                b.LaneMask[i] = (base + i) < realEnd;
            end
            expected.push_back(b);
        end
    endtask

    // Both groups or neither depending on free entries
    task automatic handlePush(input logic [1:0] primType);
        int c0;
        int c1;
        int needed;
        c0 = int'(group0Shadow[23:16]);
        c1 = int'(group1Shadow[23:16]);
        needed = (c0 != 0) + (c1 != 0);
        if (needed <= 7 - occupancy) begin
            occupancy += needed;
            if (c0 != 0) appendGroup(primType, int'(group0Shadow[15:0]), c0);
            if (c1 != 0) appendGroup(primType, int'(group1Shadow[15:0]), c1);
        end
    endtask

    task automatic compareBatch();
        primDispatchPkg::PrimitiveBatch e;
        if (expected.size() == 0) begin
            $display("A batch was transferred while no batch was expected");
            errors++;
        end else begin
            e = expected.pop_front();
            if (batch.PrimType != e.PrimType) begin
                $display("FAIL PrimType expected %h actual %h", e.PrimType, batch.PrimType);
                errors++;
            end
            if (batch.BaseIndex != e.BaseIndex) begin
                $display("FAIL BaseIndex expected %h actual %h", e.BaseIndex, batch.BaseIndex);
                errors++;
            end
            if (batch.LaneMask != e.LaneMask) begin
                $display("FAIL LaneMask expected %h actual %h", e.LaneMask, batch.LaneMask);
                errors++;
            end
        end
    endtask

    //----------------------------------------------------------------------
    // Sampled at the edge before any update
    //----------------------------------------------------------------------
    always @(posedge clk) begin
        if (!resetn) begin
            expected.delete();
            occupancy = 0;
        end else begin
            if (batchValid && batchTake) compareBatch();
            if (wbRsp.Ack && wbReq.Cyc && wbReq.Stb && wbReq.We) begin
                case (wbReq.Adr)
                    `LEAF_ADDR_GROUP0: group0Shadow = wbReq.Dat;
                    `LEAF_ADDR_GROUP1: group1Shadow = wbReq.Dat;
                    `LEAF_ADDR_CTRL: begin
                        if (wbReq.Dat[1:0] == 2'd1) begin
                            handlePush(wbReq.Dat[3:2]);
                        end else if (wbReq.Dat[1:0] == 2'd2) begin
                            if (expected.size() != 0) begin
                                $display("Restart came while batches were still pending");
                                errors++;
                            end
                            expected.delete();
                            occupancy = 1;
                            appendGroup(2'd1, `BVH_GLOBAL_PRIMITIVE_START_IDX,
                                        `BVH_GLOBAL_PRIMITIVE_COUNT);
                        end
                    end
                    default: ;
                endcase
            end
            // Loaded group leaves the FIFO after any push on the same edge
            if (load) occupancy--;
        end
        pendingCount = expected.size();
    end

    // Anything still queued at the end never came out
    always @(posedge finalCheck) begin
        if (expected.size() != 0) begin
            $display("%0d expected batches were never transferred", expected.size());
            errors++;
        end
    end

    assign errorCount = errors;

endmodule

// File: verif/tbTop.sv
// Testbench top of the primitive dispatch stage
// Galois LFSR stimulus, Wishbone host tasks, test sequence and watchdog

`timescale 1ns/10ps
`include "primDispatch_params.svh"

module tbTop;

    localparam int plannedWrites = 201;
    localparam longint timeoutNs = (40 * plannedWrites + 2000) * 10;

    logic clk;
    logic resetn;
    primDispatchPkg::WbRequest wbReq;
    primDispatchPkg::WbResponse wbRsp;
    primDispatchPkg::PrimitiveBatch batch;
    logic batchValid;
    logic batchTake;
    logic finalCheck;
    logic [31:0] lfsrState = 32'h2736;
    int takeMode;
    int hostErrors;
    int chkErrors;
    int pendingCount;

    tbClock uClock (.clk(clk), .resetn(resetn));

    primDispatch DUT (
        .clk(clk),
        .resetn(resetn),
        .wbReq(wbReq),
        .wbRsp(wbRsp),
        .batch(batch),
        .batchValid(batchValid),
        .batchTake(batchTake)
    );

    tbChecker uChecker (
        .clk(clk),
        .resetn(resetn),
        .wbReq(wbReq),
        .wbRsp(wbRsp),
        .batch(batch),
        .batchValid(batchValid),
        .batchTake(batchTake),
        .load(DUT.load),
        .finalCheck(finalCheck),
        .errorCount(chkErrors),
        .pendingCount(pendingCount)
    );

    //----------------------------------------------------------------------
    // Galois LFSR stepped once per bit
    //----------------------------------------------------------------------
    function automatic logic lfsrBit();
        logic lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) lfsrState = lfsrState ^ 32'h8020_0003;
        return lsb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsrBit()};
        return v;
    endfunction

    // Consumer mode 0 takes at random, 1 stalls, 2 always takes
    always @(posedge clk) begin
        case (takeMode)
            0: batchTake <= lfsrBit();
            1: batchTake <= 1'b0;
            default: batchTake <= 1'b1;
        endcase
    end

    //----------------------------------------------------------------------
    // Wishbone host
    //----------------------------------------------------------------------
    task automatic wbAccess(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
        primDispatchPkg::WbRequest req;
        int waitCycles;
        req.Cyc = 1'b1;
        req.Stb = 1'b1;
        req.We = we;
        req.Adr = adr;
        req.Dat = dat;
        @(posedge clk);
        wbReq <= req;
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
        end while (!wbRsp.Ack && waitCycles < 20);
        if (!wbRsp.Ack) begin
            $display("Wishbone access got no acknowledge");
            hostErrors++;
        end
        rdat = wbRsp.Dat;
        @(posedge clk);
        wbReq <= '0;
    endtask

    task automatic wbWrite(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wbAccess(1'b1, adr, dat, unused);
    endtask

    task automatic readStatus(output logic [31:0] value);
        wbAccess(1'b0, `LEAF_ADDR_STATUS, 32'h0, value);
    endtask

    task automatic expectStatus(input logic [31:0] mask, input logic [31:0] want);
        logic [31:0] value;
        readStatus(value);
        if ((value & mask) != want) begin
            $display("FAIL STATUS expected %h actual %h", want, value & mask);
            hostErrors++;
        end
    endtask

    task automatic pushLeaf(input logic [1:0] primType, input logic [15:0] s0,
                            input logic [7:0] c0, input logic [15:0] s1, input logic [7:0] c1);
        wbWrite(`LEAF_ADDR_GROUP0, {8'h00, c0, s0});
        wbWrite(`LEAF_ADDR_GROUP1, {8'h00, c1, s1});
        wbWrite(`LEAF_ADDR_CTRL, {28'h0, primType, 2'd1});
    endtask

    task automatic restartRay();
        wbWrite(`LEAF_ADDR_CTRL, 32'h2);
    endtask

    // Poll until idle with nothing left in the model, then check STATUS
    task automatic drain(input logic [31:0] mask, input logic [31:0] want);
        logic [31:0] value;
        int polls;
        polls = 0;
        do begin
            readStatus(value);
            polls++;
        end while (!(value[0] && pendingCount == 0) && polls < 2000);
        if (polls >= 2000) begin
            $display("Batches did not drain, the stage never became idle");
            hostErrors++;
        end
        expectStatus(mask, want);
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------
    initial begin
        logic [31:0] value;
        primDispatchPkg::PrimitiveBatch held;
        int waitCycles;
        logic [7:0] c0;
        logic [7:0] c1;
        wbReq = '0;
        batchTake = 1'b0;
        finalCheck = 1'b0;
        takeMode = 2;
        hostErrors = 0;
        @(posedge resetn);

        // After reset
        expectStatus(32'hFFFF_FFFF, 32'h1);
        repeat (20) @(posedge clk);

        // Restart gives the global group
        restartRay();
        drain(32'hFFFF_FFFF, 32'h1);

        // Random pushes with a zero count now and then
        takeMode = 0;
        for (int n = 0; n < 60; n++) begin
            // Drawn away from the edge where the consumer draws
            @(negedge clk);
            c0 = (randBits(2) == 0) ? 8'd0 : 8'(randBits(5));
            c1 = (randBits(2) == 0) ? 8'd0 : 8'(randBits(5));
            pushLeaf(2'(randBits(2) % 3), 16'(randBits(15)), c0, 16'(randBits(15)), c1);
        end
        drain(32'h71, 32'h1);
        restartRay();
        drain(32'hFFFF_FFFF, 32'h1);

        // Back-pressure holds the output
        takeMode = 1;
        pushLeaf(2'd2, 16'h0203, 8'd20, 16'h0000, 8'd0);
        waitCycles = 0;
        while (!batchValid && waitCycles < 100) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!batchValid) begin
            $display("No batch appeared after the back-pressure push");
            hostErrors++;
        end
        held = batch;
        repeat (30) begin
            @(negedge clk);
            if (!batchValid) begin
                $display("FAIL batchValid expected %h actual %h", 1'b1, batchValid);
                hostErrors++;
            end
            if (batch != held) begin
                $display("FAIL batch expected %h actual %h", held, batch);
                hostErrors++;
            end
        end
        takeMode = 0;
        drain(32'hFFFF_FFFF, 32'h1);

        // Fill the FIFO under back-pressure, then overflow
        takeMode = 1;
        pushLeaf(2'd0, 16'h1000, 8'd8, 16'h1100, 8'd4);
        waitCycles = 0;
        do begin
            readStatus(value);
            waitCycles++;
        end while (value[6:4] != 3'd1 && waitCycles < 50);
        if (value[6:4] != 3'd1) begin
            $display("The first group was never loaded under back-pressure");
            hostErrors++;
        end
        for (int n = 0; n < 3; n++) begin
            pushLeaf(2'd1, 16'h2000 + 16'(n * 64), 8'd5, 16'h3000 + 16'(n * 64), 8'd7);
        end
        expectStatus(32'hFFFF_FFFF, 32'h70);
        pushLeaf(2'd2, 16'h4000, 8'd9, 16'h4100, 8'd3);
        expectStatus(32'hFFFF_FFFF, 32'h72);
        takeMode = 0;
        drain(32'hFFFF_FFFF, 32'h3);
        restartRay();
        drain(32'hFFFF_FFFF, 32'h1);

        // Idle at the end
        expectStatus(32'hFFFF_FFFF, 32'h1);
        finalCheck = 1'b1;
        repeat (2) @(posedge clk);
        $display("Errors: checker %0d, host %0d", chkErrors, hostErrors);
        if (chkErrors == 0 && hostErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the planned writes
    initial begin
        #(timeoutNs);
        $display("Timeout, the test sequence did not finish in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+hdl
hdl/primDispatchPkg.sv
hdl/leafRegs.sv
hdl/primitiveQueue.sv
hdl/batchIssue.sv
hdl/primDispatch.sv
verif/tbClock.sv
verif/tbChecker.sv
verif/tbTop.sv

// File: run.sh
#!/bin/bash
# Build and run the dispatch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbTop -f src.f -o simv

output="$(./obj_dir/simv)"
echo "$output"

if grep -qx "TB PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
